/* soc_pkg.sv */
// --------------------------------------------------------------------------
// SoC harness bus widths and address map
// --------------------------------------------------------------------------

package soc_pkg;

  // Bus widths
  localparam int unsigned AddrWidth       = 32;
  localparam int unsigned DataWidth       = 64;
  localparam int unsigned StrbWidth       = DataWidth / 8;
  localparam int unsigned ByteOffsetWidth = $clog2(StrbWidth);

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  localparam logic [AddrWidth-1:0] RomBase       = 32'h0000_1000;
  localparam int unsigned          RomWords      = 128;
  localparam logic [AddrWidth-1:0] RomLength     = AddrWidth'(RomWords * StrbWidth);
  localparam int unsigned          RomIndexWidth = $clog2(RomWords);

  localparam logic [AddrWidth-1:0] ClintBase      = 32'h0200_0000;
  localparam logic [AddrWidth-1:0] ClintLength    = 32'h0000_C000;
  localparam logic [AddrWidth-1:0] MtimecmpOffset = 32'h0000_4000;
  localparam logic [AddrWidth-1:0] MtimeOffset    = 32'h0000_BFF8;

  // Always answered by the error path
  localparam logic [AddrWidth-1:0] GpioBase   = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] GpioLength = 32'h0000_1000;

  localparam logic [AddrWidth-1:0] SramBase       = 32'h8000_0000;
  localparam int unsigned          SramWords      = 256;
  localparam logic [AddrWidth-1:0] SramLength     = AddrWidth'(SramWords * StrbWidth);
  localparam int unsigned          SramIndexWidth = $clog2(SramWords);

  // Word index wide enough for the largest window
  localparam int unsigned IndexWidth = $clog2(ClintLength / StrbWidth);

  localparam logic [IndexWidth-1:0] MtimecmpIndex = IndexWidth'(MtimecmpOffset >> ByteOffsetWidth);
  localparam logic [IndexWidth-1:0] MtimeIndex    = IndexWidth'(MtimeOffset >> ByteOffsetWidth);

  localparam logic [DataWidth-1:0] RomSeed = 64'h9E37_79B9_7F4A_7C15;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } op_e;

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_SRAM,
    TGT_CLINT,
    TGT_ERR
  } target_e;

  // ROM word k holds the seed plus its index
  function automatic logic [DataWidth-1:0] rom_word(input int unsigned k);
    return RomSeed + DataWidth'(k);
  endfunction

  // Replace the bytes of a word whose enable is set
  function automatic logic [DataWidth-1:0] merge_bytes(
    input logic [DataWidth-1:0] old_data,
    input logic [DataWidth-1:0] wdata,
    input logic [StrbWidth-1:0] be
  );
    logic [DataWidth-1:0] res;
    res = old_data;
    for (int i = 0; i < StrbWidth; i++) begin
      if (be[i]) begin
        res[i*8 +: 8] = wdata[i*8 +: 8];
      end
    end
    return res;
  endfunction

endpackage

/* soc_bus_if.sv */
// --------------------------------------------------------------------------
// Internal request and response channels
// --------------------------------------------------------------------------

`timescale 1ns/1ps

// Decoded request, address already turned into a word index
interface soc_req_if;
  import soc_pkg::*;

  logic                  valid;
  logic                  ready;
  op_e                   op;
  target_e               target;
  logic [IndexWidth-1:0] index;
  logic [DataWidth-1:0]  wdata;
  logic [StrbWidth-1:0]  be;

  modport source (output valid, op, target, index, wdata, be, input ready);
  modport sink   (input valid, op, target, index, wdata, be, output ready);
endinterface

interface soc_rsp_if;
  import soc_pkg::*;

  logic                 valid;
  logic                 ready;
  logic [DataWidth-1:0] rdata;
  logic                 err;

  modport source (output valid, rdata, err, input ready);
  modport sink   (input valid, rdata, err, output ready);
endinterface

/* boot_rom.sv */
// --------------------------------------------------------------------------
// Boot ROM
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module boot_rom (
  input  logic                              clk_i,
  input  logic [soc_pkg::RomIndexWidth-1:0] index_i,
  output logic [soc_pkg::DataWidth-1:0]     rdata_o
);
  import soc_pkg::*;

  logic [DataWidth-1:0] rom [RomWords];

  // Constant table built from the package rule
  for (genvar k = 0; k < RomWords; k++) begin : g_rom_word
    assign rom[k] = rom_word(k);
  end

  // Registered read port
  always_ff @(posedge clk_i) begin
    rdata_o <= rom[index_i];
  end

endmodule

/* sram_bank.sv */
// --------------------------------------------------------------------------
// Byte-enabled SRAM
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module sram_bank (
  input  logic                               clk_i,
  input  logic                               en_i,
  input  soc_pkg::op_e                       op_i,
  input  logic [soc_pkg::SramIndexWidth-1:0] index_i,
  input  logic [soc_pkg::DataWidth-1:0]      wdata_i,
  input  logic [soc_pkg::StrbWidth-1:0]      be_i,
  output logic [soc_pkg::DataWidth-1:0]      rdata_o
);
  import soc_pkg::*;

  logic [DataWidth-1:0] mem_q [SramWords];

  // Single port, one access per enabled cycle
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (op_i == OP_WRITE) begin
        mem_q[index_i] <= merge_bytes(mem_q[index_i], wdata_i, be_i);
      end else begin
        // Read data holds until the next enabled read
        rdata_o <= mem_q[index_i];
      end
    end
  end

endmodule

/* clint_timer.sv */
// --------------------------------------------------------------------------
// Core-local timer
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module clint_timer (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           rtc_i,
  input  logic                           en_i,
  input  soc_pkg::op_e                   op_i,
  input  logic [soc_pkg::IndexWidth-1:0] index_i,
  input  logic [soc_pkg::DataWidth-1:0]  wdata_i,
  input  logic [soc_pkg::StrbWidth-1:0]  be_i,
  output logic [soc_pkg::DataWidth-1:0]  rdata_o,
  output logic                           err_o,
  output logic                           timer_irq_o
);
  import soc_pkg::*;

  logic [1:0]           rtc_sync_q;
  logic                 rtc_prev_q;
  logic                 tick;
  logic                 sel_mtime;
  logic                 sel_mtimecmp;
  logic                 wr_mtime;
  logic                 wr_mtimecmp;
  logic [DataWidth-1:0] mtime_q;
  logic [DataWidth-1:0] mtimecmp_q;

  // rtc_i is asynchronous to clk_i
  assign tick = rtc_sync_q[1] & ~rtc_prev_q;

  assign sel_mtime    = (index_i == MtimeIndex);
  assign sel_mtimecmp = (index_i == MtimecmpIndex);
  assign wr_mtime     = en_i & (op_i == OP_WRITE) & sel_mtime;
  assign wr_mtimecmp  = en_i & (op_i == OP_WRITE) & sel_mtimecmp;

  // --------------------------------------------------------------------------
  // Timer registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      // A software write wins over a tick in the same cycle
      if (wr_mtime) begin
        mtime_q <= merge_bytes(mtime_q, wdata_i, be_i);
      end else if (tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_mtimecmp) begin
        mtimecmp_q <= merge_bytes(mtimecmp_q, wdata_i, be_i);
      end
    end
  end

  // Read data and error for the current access
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      err_o   <= ~(sel_mtime | sel_mtimecmp);
      rdata_o <= sel_mtime ? mtime_q : mtimecmp_q;
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

/* bus_decode.sv */
// --------------------------------------------------------------------------
// Request register and address decoder
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module bus_decode (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_valid_i,
  input  soc_pkg::op_e                   req_op_i,
  input  logic [soc_pkg::AddrWidth-1:0]  req_addr_i,
  input  logic [soc_pkg::DataWidth-1:0]  req_wdata_i,
  input  logic [soc_pkg::StrbWidth-1:0]  req_be_i,
  output logic                           req_ready_o,
  soc_req_if.source                      dec_o
);
  import soc_pkg::*;

  logic                  accept;
  logic                  valid_q;
  target_e               target_d;
  logic [AddrWidth-1:0]  offset_d;

  // Address map lookup with the offset relative to the matched window
  always_comb begin
    // GPIO, unmapped space and ROM writes keep the error target
    target_d = TGT_ERR;
    offset_d = '0;
    if (req_addr_i >= RomBase && req_addr_i < RomBase + RomLength) begin
      offset_d = req_addr_i - RomBase;
      target_d = (req_op_i == OP_WRITE) ? TGT_ERR : TGT_ROM;
    end else if (req_addr_i >= SramBase && req_addr_i < SramBase + SramLength) begin
      offset_d = req_addr_i - SramBase;
      target_d = TGT_SRAM;
    end else if (req_addr_i >= ClintBase && req_addr_i < ClintBase + ClintLength) begin
      offset_d = req_addr_i - ClintBase;
      target_d = TGT_CLINT;
    end
  end

  assign req_ready_o = ~valid_q | dec_o.ready;
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (dec_o.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_o.op     <= req_op_i;
      dec_o.target <= target_d;
      dec_o.index  <= offset_d[ByteOffsetWidth +: IndexWidth];
      dec_o.wdata  <= req_wdata_i;
      dec_o.be     <= req_be_i;
    end
  end

  assign dec_o.valid = valid_q;

endmodule

/* bus_execute.sv */
// --------------------------------------------------------------------------
// Execute stage with ROM, SRAM and timer
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module bus_execute (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      rtc_i,
  soc_req_if.sink   dec_i,
  soc_rsp_if.source exe_o,
  output logic      timer_irq_o
);
  import soc_pkg::*;

  logic                     fire;
  logic                     sram_en;
  logic                     clint_en;
  logic                     valid_q;
  target_e                  tgt_q;
  op_e                      op_q;
  logic [RomIndexWidth-1:0] rom_index;
  logic [RomIndexWidth-1:0] rom_index_q;
  logic [DataWidth-1:0]     rom_rdata;
  logic [DataWidth-1:0]     sram_rdata;
  logic [DataWidth-1:0]     clint_rdata;
  logic                     clint_err;

  assign dec_i.ready = ~valid_q | exe_o.ready;
  assign fire        = dec_i.valid & dec_i.ready;
  assign sram_en     = fire & (dec_i.target == TGT_SRAM);
  assign clint_en    = fire & (dec_i.target == TGT_CLINT);

  // ROM output follows its index every cycle, so hold it while stalled
  assign rom_index = fire ? dec_i.index[RomIndexWidth-1:0] : rom_index_q;

  boot_rom u_boot_rom (
    .clk_i   ( clk_i     ),
    .index_i ( rom_index ),
    .rdata_o ( rom_rdata )
  );

  sram_bank u_sram_bank (
    .clk_i   ( clk_i                             ),
    .en_i    ( sram_en                           ),
    .op_i    ( dec_i.op                          ),
    .index_i ( dec_i.index[SramIndexWidth-1:0]   ),
    .wdata_i ( dec_i.wdata                       ),
    .be_i    ( dec_i.be                          ),
    .rdata_o ( sram_rdata                        )
  );

  clint_timer u_clint_timer (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .en_i        ( clint_en    ),
    .op_i        ( dec_i.op    ),
    .index_i     ( dec_i.index ),
    .wdata_i     ( dec_i.wdata ),
    .be_i        ( dec_i.be    ),
    .rdata_o     ( clint_rdata ),
    .err_o       ( clint_err   ),
    .timer_irq_o ( timer_irq_o )
  );

  // --------------------------------------------------------------------------
  // Response entry
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (fire) begin
      valid_q <= 1'b1;
    end else if (exe_o.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      tgt_q       <= dec_i.target;
      op_q        <= dec_i.op;
      rom_index_q <= dec_i.index[RomIndexWidth-1:0];
    end
  end

  // Target read registers were loaded on the same edge as the entry
  always_comb begin
    exe_o.rdata = '0;
    exe_o.err   = 1'b0;
    case (tgt_q)
      TGT_ROM:  exe_o.rdata = rom_rdata;
      TGT_SRAM: begin
        if (op_q == OP_READ) begin
          exe_o.rdata = sram_rdata;
        end
      end
      TGT_CLINT: begin
        exe_o.err = clint_err;
        if (op_q == OP_READ && !clint_err) begin
          exe_o.rdata = clint_rdata;
        end
      end
      default:  exe_o.err = 1'b1;
    endcase
  end

  assign exe_o.valid = valid_q;

endmodule

/* bus_result.sv */
// --------------------------------------------------------------------------
// Two-entry response FIFO
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module bus_result (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  soc_rsp_if.sink                       exe_i,
  input  logic                          rsp_ready_i,
  output logic                          rsp_valid_o,
  output logic [soc_pkg::DataWidth-1:0] rsp_rdata_o,
  output logic                          rsp_err_o
);
  import soc_pkg::*;

  logic [DataWidth-1:0] rdata_q [2];
  logic [1:0]           err_q;
  logic                 wr_ptr_q;
  logic                 rd_ptr_q;
  logic [1:0]           count_q;
  logic                 push;
  logic                 pop;

  // Ready comes from the fill level only
  assign exe_i.ready = (count_q != 2'd2);
  assign rsp_valid_o = (count_q != 2'd0);
  assign push        = exe_i.valid & exe_i.ready;
  assign pop         = rsp_valid_o & rsp_ready_i;

  assign rsp_rdata_o = rdata_q[rd_ptr_q];
  assign rsp_err_o   = err_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      rdata_q[wr_ptr_q] <= exe_i.rdata;
      err_q[wr_ptr_q]   <= exe_i.err;
    end
  end

endmodule

/* soc_harness.sv */
// --------------------------------------------------------------------------
// SoC memory-mapped harness top
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module soc_harness (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rtc_i,
  input  logic                          req_valid_i,
  input  soc_pkg::op_e                  req_op_i,
  input  logic [soc_pkg::AddrWidth-1:0] req_addr_i,
  input  logic [soc_pkg::DataWidth-1:0] req_wdata_i,
  input  logic [soc_pkg::StrbWidth-1:0] req_be_i,
  input  logic                          rsp_ready_i,
  output logic                          req_ready_o,
  output logic                          rsp_valid_o,
  output logic [soc_pkg::DataWidth-1:0] rsp_rdata_o,
  output logic                          rsp_err_o,
  output logic                          timer_irq_o
);

  // Decode to execute, then execute to response buffer
  soc_req_if dec_if ();
  soc_rsp_if exe_if ();

  bus_decode u_bus_decode (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_valid_i ( req_valid_i ),
    .req_op_i    ( req_op_i    ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .req_be_i    ( req_be_i    ),
    .req_ready_o ( req_ready_o ),
    .dec_o       ( dec_if      )
  );

  bus_execute u_bus_execute (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .dec_i       ( dec_if      ),
    .exe_o       ( exe_if      ),
    .timer_irq_o ( timer_irq_o )
  );

  bus_result u_bus_result (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .exe_i       ( exe_if      ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_err_o   ( rsp_err_o   )
  );

endmodule

/* tb_soc_harness.sv */
// --------------------------------------------------------------------------
// SoC harness testbench
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_soc_harness;
  import soc_pkg::*;

  localparam int unsigned NumRomReads   = RomWords;
  localparam int unsigned NumRomWrites  = 4;
  localparam int unsigned NumSramOps    = 300;
  localparam int unsigned NumErrOps     = 40;
  localparam int unsigned NumTimerOps   = 5;
  localparam int unsigned NumReqs       = NumRomReads + NumRomWrites + NumSramOps +
                                          NumErrOps + NumTimerOps;
  localparam int unsigned TimeoutCycles = 40 * NumReqs;
  localparam logic [31:0] Seed          = 32'h186a3531;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 rtc_i;
  logic                 req_valid_i;
  op_e                  req_op_i;
  logic [AddrWidth-1:0] req_addr_i;
  logic [DataWidth-1:0] req_wdata_i;
  logic [StrbWidth-1:0] req_be_i;
  logic                 rsp_ready_i;
  logic                 req_ready_o;
  logic                 rsp_valid_o;
  logic [DataWidth-1:0] rsp_rdata_o;
  logic                 rsp_err_o;
  logic                 timer_irq_o;

  // Expected responses in request order
  logic [DataWidth-1:0] exp_data_q [$];
  logic [DataWidth-1:0] exp_mask_q [$];
  logic                 exp_err_q [$];

  logic [DataWidth-1:0] sram_shadow [SramWords];
  logic [DataWidth-1:0] sram_written [SramWords];
  logic [DataWidth-1:0] mtime_shadow;
  logic [DataWidth-1:0] mtimecmp_shadow;
  logic [31:0]          stim_state;
  logic [31:0]          stall_state;
  int unsigned          rsp_count;
  int unsigned          cycle_count;

  soc_harness u_soc_harness (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .req_valid_i ( req_valid_i ),
    .req_op_i    ( req_op_i    ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .req_be_i    ( req_be_i    ),
    .rsp_ready_i ( rsp_ready_i ),
    .req_ready_o ( req_ready_o ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_err_o   ( rsp_err_o   ),
    .timer_irq_o ( timer_irq_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  function automatic logic [63:0] byte_mask(input logic [7:0] be);
    logic [63:0] m;
    for (int i = 0; i < 8; i++) begin
      m[i*8 +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // --------------------------------------------------------------------------
  // Reference model of the address map
  // --------------------------------------------------------------------------
  function automatic void predict(input op_e op, input logic [31:0] addr,
                                  input logic [63:0] wdata, input logic [7:0] be);
    logic [63:0] data;
    logic [63:0] mask;
    logic [63:0] m;
    logic        err;
    logic [31:0] off;
    int unsigned idx;
    data = '0;
    mask = '1;
    err  = 1'b0;
    m    = byte_mask(be);
    if (addr >= RomBase && addr < RomBase + 32'(RomWords * 8)) begin
      if (op == OP_WRITE) err = 1'b1;
      else data = RomSeed + 64'((addr - RomBase) >> 3);
    end else if (addr >= SramBase && addr < SramBase + 32'(SramWords * 8)) begin
      idx = int'((addr - SramBase) >> 3);
      if (op == OP_WRITE) begin
        sram_shadow[idx]  = (sram_shadow[idx] & ~m) | (wdata & m);
        sram_written[idx] = sram_written[idx] | m;
      end else begin
        // Bytes never written are not compared
        data = sram_shadow[idx];
        mask = sram_written[idx];
      end
    end else if (addr >= ClintBase && addr < ClintBase + ClintLength) begin
      off = addr - ClintBase;
      if (off == MtimecmpOffset) begin
        if (op == OP_WRITE) mtimecmp_shadow = (mtimecmp_shadow & ~m) | (wdata & m);
        else data = mtimecmp_shadow;
      end else if (off == MtimeOffset) begin
        if (op == OP_WRITE) mtime_shadow = (mtime_shadow & ~m) | (wdata & m);
        else data = mtime_shadow;
      end else begin
        err = 1'b1;
      end
    end else begin
      err = 1'b1;
    end
    exp_data_q.push_back(data);
    exp_mask_q.push_back(mask);
    exp_err_q.push_back(err);
  endfunction

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send(input op_e op, input logic [31:0] addr,
                      input logic [63:0] wdata, input logic [7:0] be);
    logic accepted;
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_be_i    = be;
    accepted    = 1'b0;
    while (!accepted) begin
      accepted = req_ready_o;
      if (accepted) predict(op, addr, wdata, be);
      @(negedge clk_i);
    end
    req_valid_i = 1'b0;
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic wait_idle();
    while (exp_data_q.size() != 0) @(negedge clk_i);
  endtask

  // One rising rtc edge held long enough to pass the synchronizer
  task automatic rtc_tick();
    rtc_i        = 1'b1;
    mtime_shadow = mtime_shadow + 64'd1;
    idle(4);
    rtc_i = 1'b0;
    idle(4);
  endtask

  // --------------------------------------------------------------------------
  // Response checker with random back-pressure
  // --------------------------------------------------------------------------
  initial begin : compare_proc
    logic [31:0] r;
    logic [63:0] exp_data;
    logic [63:0] exp_mask;
    logic        exp_err;
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        r           = lcg_next(stall_state);
        rsp_ready_i = (r[31:30] != 2'b00);
        if (rsp_valid_o && rsp_ready_i) begin
          if (exp_data_q.size() == 0) begin
            abort_run("response arrived with no request outstanding");
          end else begin
            exp_data = exp_data_q.pop_front();
            exp_mask = exp_mask_q.pop_front();
            exp_err  = exp_err_q.pop_front();
            check("rsp_rdata_o", rsp_rdata_o & exp_mask, exp_data & exp_mask);
            check("rsp_err_o", 64'(rsp_err_o), 64'(exp_err));
            rsp_count++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    abort_run("timeout, not all responses came back in time");
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] off;
    logic [63:0] wdata;
    op_e         op;
    rst_ni          = 1'b0;
    rtc_i           = 1'b0;
    req_valid_i     = 1'b0;
    req_op_i        = OP_READ;
    req_addr_i      = '0;
    req_wdata_i     = '0;
    req_be_i        = '0;
    rsp_ready_i     = 1'b0;
    stim_state      = Seed;
    stall_state     = Seed;
    mtime_shadow    = '0;
    mtimecmp_shadow = '1;
    rsp_count       = 0;
    for (int i = 0; i < SramWords; i++) begin
      sram_shadow[i]  = '0;
      sram_written[i] = '0;
    end
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check("timer_irq_o", 64'(timer_irq_o), 64'd0);

    // ROM reads over every word, then writes that must fail
    for (int k = 0; k < NumRomReads; k++) begin
      send(OP_READ, RomBase + 32'(k * 8), '0, 8'hFF);
    end
    for (int k = 0; k < NumRomWrites; k++) begin
      r = lcg_next(stim_state);
      send(OP_WRITE, RomBase + {22'd0, r[31:25], 3'b000}, {r, r}, 8'hFF);
    end

    // SRAM traffic on a few words so that reads hit earlier writes
    for (int n = 0; n < NumSramOps; n++) begin
      r            = lcg_next(stim_state);
      wdata[63:32] = lcg_next(stim_state);
      wdata[31:0]  = lcg_next(stim_state);
      addr         = SramBase + {24'd0, r[31:27], 3'b000};
      op           = r[26] ? OP_WRITE : OP_READ;
      send(op, addr, wdata, r[25:18]);
      if (r[17:16] == 2'b11) idle(1);
    end

    // GPIO, unmapped space and unused timer offsets
    for (int n = 0; n < NumErrOps; n++) begin
      r   = lcg_next(stim_state);
      off = {16'd0, r[15:3], 3'b000};
      case (r[31:30])
        2'b00:   addr = GpioBase + {20'd0, r[11:3], 3'b000};
        2'b01:   addr = 32'h1000_0000 + off;
        2'b10:   addr = SramBase + SramLength + {20'd0, r[11:3], 3'b000};
        default: begin
          if (off == MtimecmpOffset || off == MtimeOffset) off = off - 32'd8;
          addr = ClintBase + off;
        end
      endcase
      op = r[29] ? OP_WRITE : OP_READ;
      send(op, addr, {r, ~r}, 8'hFF);
    end

    // mtime follows the rtc edge count
    for (int round = 0; round < 3; round++) begin
      wait_idle();
      r = lcg_next(stim_state);
      repeat (int'(r[31:29]) + 1) rtc_tick();
      send(OP_READ, ClintBase + MtimeOffset, '0, 8'hFF);
      wait_idle();
    end

    // Interrupt rises once mtime reaches mtimecmp
    send(OP_WRITE, ClintBase + MtimecmpOffset, mtime_shadow + 64'd3, 8'hFF);
    send(OP_READ, ClintBase + MtimecmpOffset, '0, 8'hFF);
    wait_idle();
    check("timer_irq_o", 64'(timer_irq_o), 64'd0);
    for (int t = 0; t < 6; t++) begin
      rtc_tick();
      check("timer_irq_o", 64'(timer_irq_o), 64'(mtime_shadow >= mtimecmp_shadow));
    end

    while (rsp_count < NumReqs) @(negedge clk_i);
    // No response may follow the last expected one
    idle(8);
    if (rsp_valid_o) begin
      abort_run("extra response after every request was answered");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

/* project.f */
soc_pkg.sv
soc_bus_if.sv
boot_rom.sv
sram_bank.sv
clint_timer.sv
bus_decode.sv
bus_execute.sv
bus_result.sv
soc_harness.sv
tb_soc_harness.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_soc_harness -o tb_sim
status=0
out=$(./obj_dir/tb_sim 2>&1) || status=$?
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
echo "simulation did not pass, exit status $status"
exit 1
